// ==== fifo_macros.svh ====
/*
  Default sizing of the credit FIFO.
  Include this header wherever the depth, entry width or bypass mode is
  needed. The type packages take their widths from these values, so a
  different FIFO size means editing the values here and rebuilding.
*/

`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// ----------------------------------------------------------------------
// FIFO geometry
// ----------------------------------------------------------------------

// Number of entries held in the external RAM, at least 2
`define FIFO_DEPTH 4

// Bits carried by one entry
`define FIFO_WIDTH 8

// ----------------------------------------------------------------------
// Latency mode
// ----------------------------------------------------------------------

// With 1 a push into an empty FIFO shows up at the pop side in the
// same cycle; with 0 every item goes through the RAM first
`define FIFO_BYPASS 1

`endif

// ==== fifo_pkg.sv ====
/*
  Data, address and count types of the FIFO datapath.
  Imported by the controllers, the RAM and the top level. All widths
  follow the depth and width defaults in the macros header.
*/

`include "fifo_macros.svh"

package fifo_pkg;

  // Address bits needed to index every RAM entry
  localparam int AddrWidth = $clog2(`FIFO_DEPTH);

  // A count runs from 0 to the full depth, so it needs one extra bit
  localparam int CountWidth = AddrWidth + 1;

  // One stored entry
  typedef logic [`FIFO_WIDTH-1:0] fifo_data_t;

  // RAM address used by both pointers
  typedef logic [AddrWidth-1:0] fifo_addr_t;

  // Item or free-slot count
  typedef logic [CountWidth-1:0] fifo_count_t;

  // Highest address, where the pointers wrap back to 0
  localparam fifo_addr_t LastAddr = fifo_addr_t'(`FIFO_DEPTH - 1);

  // Depth as a count, the reset value of the free-slot counter
  localparam fifo_count_t FifoDepth = fifo_count_t'(`FIFO_DEPTH);

endpackage

// ==== credit_pkg.sv ====
/*
  Types of the push-side credit loop.
  Imported by the configuration block, the push controller and the top
  level. Credits share the width of a FIFO count but carry a meaning
  of their own, so they get a separate type.
*/

`include "fifo_macros.svh"

package credit_pkg;

  // Credits run from 0 up to the depth
  localparam int CreditWidth = $clog2(`FIFO_DEPTH) + 1;

  // Credit count, available credits or withhold amount
  typedef logic [CreditWidth-1:0] credit_t;

  // The FIFO owns every credit when it comes out of reset
  localparam credit_t CreditReset = credit_t'(`FIFO_DEPTH);

endpackage

// ==== fifo_credit_cfg.sv ====
/*
  Software-visible control next to the push controller.
  A write loads the credit withhold amount, which caps how many of the
  held credits may go out to the sender. Overflow pulses from the push
  side are caught in a sticky flag that software clears.
*/

module fifo_credit_cfg
  import credit_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,

  // Register write and flag clear strobes
  input  logic    cfg_wr,
  input  logic    cfg_clr,
  input  credit_t cfg_wdata,

  // Pulse from the push controller on a push while full
  input  logic    push_overflow,

  output credit_t credit_withhold,
  output logic    overflow_sticky
);

  // ----------------------------------------------------------------------
  // Credit withhold register
  // ----------------------------------------------------------------------

  // Nothing is withheld after reset, so all credits can go out
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_withhold <= '0;
    end else if (cfg_wr) begin
      credit_withhold <= cfg_wdata;
    end
  end

  // ----------------------------------------------------------------------
  // Sticky overflow flag
  // ----------------------------------------------------------------------

  // A new overflow wins over a clear in the same cycle
  // so that no event is ever lost
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      overflow_sticky <= 1'b0;
    end else if (push_overflow) begin
      overflow_sticky <= 1'b1;
    end else if (cfg_clr) begin
      overflow_sticky <= 1'b0;
    end
  end

endmodule

// ==== fifo_push_ctrl.sv ====
/*
  Push side of the 1R1W credit FIFO controller.
  Runs the credit counter that hands credits to the sender, takes pushes
  on the credit/valid interface and either offers them to the pop side
  through the bypass or writes them into the external RAM. Also keeps
  the write pointer and the free-slot count.
*/

`include "fifo_macros.svh"

module fifo_push_ctrl
  import fifo_pkg::*, credit_pkg::*;
#(
  parameter bit EnableBypass = `FIFO_BYPASS
) (
  input  logic        clk,
  input  logic        arst_n,

  // Credit/valid push interface
  input  logic        push_credit_stall,
  output logic        push_credit,
  input  logic        push_valid,
  input  fifo_data_t  push_data,

  // Push-side status
  output logic        full,
  output logic        full_next,
  output fifo_count_t slots,
  output fifo_count_t slots_next,

  // Credit control and status
  input  credit_t     credit_withhold,
  output credit_t     credit_count,
  output credit_t     credit_available,
  output logic        push_overflow,

  // Bypass towards the pop controller
  input  logic        bypass_ready,
  output logic        bypass_valid_unstable,
  output fifo_data_t  bypass_data_unstable,

  // RAM write port
  output logic        ram_wr_valid,
  output fifo_addr_t  ram_wr_addr,
  output fifo_data_t  ram_wr_data,

  // Write and pop events shared with the pop controller
  output logic        ram_push,
  input  logic        ram_pop
);

  credit_t    credit_plus_pop;
  credit_t    credit_count_next;
  logic       push_beat;
  logic       bypass_beat;
  logic       slot_free;
  fifo_addr_t wr_ptr;

  // ----------------------------------------------------------------------
  // Credit counter
  // ----------------------------------------------------------------------

  // A pop hands its credit straight back in the same cycle
  // This is what gives a zero-cycle pop to credit latency
  assign credit_plus_pop = credit_count + credit_t'(ram_pop);

  // Credits above the withhold amount may be released, never below 0
  assign credit_available = (credit_plus_pop > credit_withhold) ?
                            credit_t'(credit_plus_pop - credit_withhold) : '0;

  assign push_credit = !push_credit_stall && (credit_available != '0);

  // A released credit and a pop in the same cycle cancel out
  assign credit_count_next = credit_plus_pop - credit_t'(push_credit);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_count <= CreditReset;
    end else begin
      credit_count <= credit_count_next;
    end
  end

  // ----------------------------------------------------------------------
  // Push acceptance and bypass
  // ----------------------------------------------------------------------

  // A push while full has no slot to go to and is dropped
  assign push_beat     = push_valid && !full;
  assign push_overflow = push_valid && full;

  // Every accepted push is offered to the pop side first
  assign bypass_valid_unstable = EnableBypass && push_beat;
  assign bypass_data_unstable  = push_data;
  assign bypass_beat           = bypass_valid_unstable && bypass_ready;

  // Only pushes the bypass did not take go into the RAM
  assign ram_push     = push_beat && !bypass_beat;
  assign ram_wr_valid = ram_push;
  assign ram_wr_addr  = wr_ptr;
  assign ram_wr_data  = push_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (ram_push) begin
      wr_ptr <= (wr_ptr == LastAddr) ? '0 : fifo_addr_t'(wr_ptr + 1'b1);
    end
  end

  // ----------------------------------------------------------------------
  // Free-slot count
  // ----------------------------------------------------------------------

  // A bypassed pop never held a slot, so only RAM pops free one
  assign slot_free  = ram_pop && !bypass_beat;
  assign slots_next = slots - fifo_count_t'(ram_push) + fifo_count_t'(slot_free);
  assign full_next  = (slots_next == '0);
  assign full       = (slots == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slots <= FifoDepth;
    end else begin
      slots <= slots_next;
    end
  end

endmodule

// ==== fifo_pop_ctrl.sv ====
/*
  Pop side of the 1R1W FIFO controller.
  Reads the head entry from the external RAM with a zero-latency read
  and offers it on the ready/valid pop interface. When the FIFO is
  empty and bypass is on, the incoming push is shown directly instead.
  Keeps the read pointer and the item count.
*/

`include "fifo_macros.svh"

module fifo_pop_ctrl
  import fifo_pkg::*;
#(
  parameter bit EnableBypass = `FIFO_BYPASS
) (
  input  logic        clk,
  input  logic        arst_n,

  // Ready/valid pop interface
  input  logic        pop_ready,
  output logic        pop_valid,
  output fifo_data_t  pop_data,

  // Pop-side status
  output logic        empty,
  output logic        empty_next,
  output fifo_count_t items,
  output fifo_count_t items_next,

  // Bypass from the push controller
  output logic        bypass_ready,
  input  logic        bypass_valid_unstable,
  input  fifo_data_t  bypass_data_unstable,

  // RAM read port
  output logic        ram_rd_addr_valid,
  output fifo_addr_t  ram_rd_addr,
  input  logic        ram_rd_data_valid,
  input  fifo_data_t  ram_rd_data,

  // Write and pop events shared with the push controller
  input  logic        ram_push,
  output logic        ram_pop
);

  logic       head_valid;
  logic       bypass_valid;
  logic       head_pop;
  fifo_addr_t rd_ptr;

  // ----------------------------------------------------------------------
  // Head of queue
  // ----------------------------------------------------------------------

  // The RAM is read at the head whenever something is stored
  assign ram_rd_addr_valid = !empty;
  assign ram_rd_addr       = rd_ptr;
  assign head_valid        = ram_rd_data_valid;

  // The bypass only applies with nothing older in the RAM
  assign bypass_valid = EnableBypass && empty && bypass_valid_unstable;
  assign bypass_ready = EnableBypass && empty && pop_ready;

  assign pop_valid = head_valid || bypass_valid;
  assign pop_data  = head_valid ? ram_rd_data : bypass_data_unstable;

  // Every handshake counts as an item leaving, bypassed or not
  assign ram_pop  = pop_valid && pop_ready;
  assign head_pop = ram_pop && head_valid;

  // ----------------------------------------------------------------------
  // Read pointer
  // ----------------------------------------------------------------------

  // The pointer stands still under back-pressure so pop_data holds
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (head_pop) begin
      rd_ptr <= (rd_ptr == LastAddr) ? '0 : fifo_addr_t'(rd_ptr + 1'b1);
    end
  end

  // ----------------------------------------------------------------------
  // Item count
  // ----------------------------------------------------------------------

  // Bypassed items never enter the count
  assign items_next = items + fifo_count_t'(ram_push) - fifo_count_t'(head_pop);
  assign empty_next = (items_next == '0);
  assign empty      = (items == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      items <= '0;
    end else begin
      items <= items_next;
    end
  end

endmodule

// ==== fifo_ram_1r1w.sv ====
/*
  Flop-based pseudo-dual-port RAM behind the FIFO controller.
  Writes land on the clock edge, one cycle of write latency. Reads are
  combinational, zero cycles of read latency, so a written entry can be
  read from the cycle after the write.
*/

`include "fifo_macros.svh"

module fifo_ram_1r1w
  import fifo_pkg::*;
(
  input  logic       clk,

  // Write port
  input  logic       wr_valid,
  input  fifo_addr_t wr_addr,
  input  fifo_data_t wr_data,

  // Read port
  input  logic       rd_addr_valid,
  input  fifo_addr_t rd_addr,
  output logic       rd_data_valid,
  output fifo_data_t rd_data
);

  // Storage array with one word per FIFO entry
  fifo_data_t mem [`FIFO_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Zero-latency read where the valid simply follows the address valid
  assign rd_data       = mem[rd_addr];
  assign rd_data_valid = rd_addr_valid;

endmodule

// ==== fifo_ctrl_1r1w_push_credit.sv ====
/*
  FIFO controller with a credit/valid push side and a ready/valid pop
  side, driving an external 1R1W RAM with write latency 1 and read
  latency 0. Holds no storage itself. The push and pop controllers
  trade write and pop events plus the bypass path that lets a push
  into an empty FIFO reach the pop side in the same cycle.
*/

`include "fifo_macros.svh"

module fifo_ctrl_1r1w_push_credit
  import fifo_pkg::*, credit_pkg::*;
#(
  parameter bit EnableBypass = `FIFO_BYPASS
) (
  input  logic        clk,
  input  logic        arst_n,
  // Push side
  input  logic        push_credit_stall,
  output logic        push_credit,
  input  logic        push_valid,
  input  fifo_data_t  push_data,
  // Pop side
  input  logic        pop_ready,
  output logic        pop_valid,
  output fifo_data_t  pop_data,
  // Status
  output logic        full,
  output logic        full_next,
  output fifo_count_t slots,
  output fifo_count_t slots_next,
  output logic        empty,
  output logic        empty_next,
  output fifo_count_t items,
  output fifo_count_t items_next,
  // Credits
  input  credit_t     credit_withhold,
  output credit_t     credit_count,
  output credit_t     credit_available,
  output logic        push_overflow,
  // 1R1W RAM
  output logic        ram_wr_valid,
  output fifo_addr_t  ram_wr_addr,
  output fifo_data_t  ram_wr_data,
  output logic        ram_rd_addr_valid,
  output fifo_addr_t  ram_rd_addr,
  input  logic        ram_rd_data_valid,
  input  fifo_data_t  ram_rd_data
);

  // Links between the two halves
  logic       bypass_ready;
  logic       bypass_valid_unstable;
  fifo_data_t bypass_data_unstable;
  logic       ram_push;
  logic       ram_pop;

  fifo_push_ctrl #(
    .EnableBypass(EnableBypass)
  ) u_push_ctrl (
    .clk,
    .arst_n,
    .push_credit_stall,
    .push_credit,
    .push_valid,
    .push_data,
    .full,
    .full_next,
    .slots,
    .slots_next,
    .credit_withhold,
    .credit_count,
    .credit_available,
    .push_overflow,
    .bypass_ready,
    .bypass_valid_unstable,
    .bypass_data_unstable,
    .ram_wr_valid,
    .ram_wr_addr,
    .ram_wr_data,
    .ram_push,
    .ram_pop
  );

  fifo_pop_ctrl #(
    .EnableBypass(EnableBypass)
  ) u_pop_ctrl (
    .clk,
    .arst_n,
    .pop_ready,
    .pop_valid,
    .pop_data,
    .empty,
    .empty_next,
    .items,
    .items_next,
    .bypass_ready,
    .bypass_valid_unstable,
    .bypass_data_unstable,
    .ram_rd_addr_valid,
    .ram_rd_addr,
    .ram_rd_data_valid,
    .ram_rd_data,
    .ram_push,
    .ram_pop
  );

endmodule

// ==== fifo_credit_top.sv ====
/*
  Top level of the credit FIFO.
  Joins the configuration block, the FIFO controller and a flop RAM.
  Software sets the credit withhold and reads and clears the sticky
  overflow flag; the push and pop interfaces go straight out.
*/

`include "fifo_macros.svh"

module fifo_credit_top
  import fifo_pkg::*, credit_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        push_credit_stall,
  output logic        push_credit,
  input  logic        push_valid,
  input  fifo_data_t  push_data,
  input  logic        pop_ready,
  output logic        pop_valid,
  output fifo_data_t  pop_data,
  output logic        full,
  output fifo_count_t slots,
  output logic        empty,
  output fifo_count_t items,
  output credit_t     credit_count,
  output credit_t     credit_available,
  input  logic        cfg_wr,
  input  logic        cfg_clr,
  input  credit_t     cfg_wdata,
  output logic        overflow_sticky
);

  credit_t    credit_withhold;
  logic       push_overflow;

  // Controller to RAM
  logic       ram_wr_valid;
  fifo_addr_t ram_wr_addr;
  fifo_data_t ram_wr_data;
  logic       ram_rd_addr_valid;
  fifo_addr_t ram_rd_addr;
  logic       ram_rd_data_valid;
  fifo_data_t ram_rd_data;

  fifo_credit_cfg u_cfg (
    .clk,
    .arst_n,
    .cfg_wr,
    .cfg_clr,
    .cfg_wdata,
    .push_overflow,
    .credit_withhold,
    .overflow_sticky
  );

  fifo_ctrl_1r1w_push_credit #(
    .EnableBypass(`FIFO_BYPASS)
  ) u_ctrl (
    .clk,
    .arst_n,
    .push_credit_stall,
    .push_credit,
    .push_valid,
    .push_data,
    .pop_ready,
    .pop_valid,
    .pop_data,
    .full,
    .full_next(),
    .slots,
    .slots_next(),
    .empty,
    .empty_next(),
    .items,
    .items_next(),
    .credit_withhold,
    .credit_count,
    .credit_available,
    .push_overflow,
    .ram_wr_valid,
    .ram_wr_addr,
    .ram_wr_data,
    .ram_rd_addr_valid,
    .ram_rd_addr,
    .ram_rd_data_valid,
    .ram_rd_data
  );

  fifo_ram_1r1w u_ram (
    .clk,
    .wr_valid(ram_wr_valid),
    .wr_addr(ram_wr_addr),
    .wr_data(ram_wr_data),
    .rd_addr_valid(ram_rd_addr_valid),
    .rd_addr(ram_rd_addr),
    .rd_data_valid(ram_rd_data_valid),
    .rd_data(ram_rd_data)
  );

endmodule

// ==== fifo_credit_props.sv ====
/*
  Concurrent checks on the credit loop and the pop interface.
  Bound into the FIFO controller, the one place that sees both the
  credit counter of the push side and the item count of the pop side.
*/

`include "fifo_macros.svh"

module fifo_credit_props
  import fifo_pkg::*, credit_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input logic        push_credit_stall,
  input logic        push_credit,
  input logic        pop_valid,
  input logic        pop_ready,
  input fifo_data_t  pop_data,
  input credit_t     credit_count,
  input fifo_count_t items
);

  timeunit 1ns;
  timeprecision 1ns;

  // Credits still held plus items stored never exceed the depth
  credit_in_bounds: assert property (
    @(posedge clk) disable iff (!arst_n)
    int'(credit_count) + int'(items) <= `FIFO_DEPTH
  ) else $error("held credits plus stored items exceed the FIFO depth");

  // No credit leaves in a stalled cycle and the held count does not fall
  stall_blocks_credit: assert property (
    @(posedge clk) disable iff (!arst_n)
    push_credit_stall |=> !$past(push_credit) && (credit_count >= $past(credit_count))
  ) else $error("credit released or held count dropped under push_credit_stall");

  // Under back-pressure the offered item stays put
  pop_data_held: assert property (
    @(posedge clk) disable iff (!arst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data)
  ) else $error("pop_data changed or pop_valid dropped under back-pressure");

endmodule

bind fifo_ctrl_1r1w_push_credit fifo_credit_props u_props (
  .clk,
  .arst_n,
  .push_credit_stall,
  .push_credit,
  .pop_valid,
  .pop_ready,
  .pop_data,
  .credit_count,
  .items
);

// ==== tb_fifo_credit.sv ====
/*
  Testbench for the credit FIFO top level.
  Applies a table of push, pop, stall and configuration steps, one row per
  clock cycle, and checks every output against a reference model of the
  queue and credit rules. Inputs change on the falling edge and outputs
  are sampled a quarter period later, well before the next rising edge.
*/

`include "fifo_macros.svh"

module tb_fifo_credit
  import fifo_pkg::*, credit_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int Period = 100;
  localparam int Depth  = `FIFO_DEPTH;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        push_credit_stall;
  logic        push_credit;
  logic        push_valid;
  fifo_data_t  push_data;
  logic        pop_ready;
  logic        pop_valid;
  fifo_data_t  pop_data;
  logic        full;
  fifo_count_t slots;
  logic        empty;
  fifo_count_t items;
  credit_t     credit_count;
  credit_t     credit_available;
  logic        cfg_wr;
  logic        cfg_clr;
  credit_t     cfg_wdata;
  logic        overflow_sticky;

  // Stimulus table, one entry per clock cycle
  string       step_q[$];
  logic        pv_q[$];
  fifo_data_t  data_q[$];
  logic        pr_q[$];
  logic        stall_q[$];
  logic        wr_q[$];
  credit_t     wdata_q[$];
  logic        clr_q[$];

  // Reference model: stored items, FIFO credits and the sender's credits
  fifo_data_t  model_q[$];
  int          model_credit;
  int          model_withhold;
  int          sender_credit;
  logic        model_sticky;

  integer      seed = 32'h808d7a4c;
  int          errors;
  int          checks;

  fifo_credit_top DUT (.*);

  always #(Period / 2) clk = ~clk;

  // ----------------------------------------------------------------------
  // Compare tasks, one per result type
  // ----------------------------------------------------------------------

  task automatic check_data(input string what, input fifo_data_t got, input fifo_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input fifo_count_t got,
                             input fifo_count_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_credit(input string what, input credit_t got, input credit_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // Table construction
  // ----------------------------------------------------------------------

  function automatic fifo_data_t next_random_data();
    return fifo_data_t'($random(seed));
  endfunction

  task automatic add_step(input string step, input logic pv, input fifo_data_t data,
                          input logic pr, input logic stall, input logic wr,
                          input credit_t wdata, input logic clr);
    step_q.push_back(step);
    pv_q.push_back(pv);
    data_q.push_back(data);
    pr_q.push_back(pr);
    stall_q.push_back(stall);
    wr_q.push_back(wr);
    wdata_q.push_back(wdata);
    clr_q.push_back(clr);
  endtask

  task automatic build_table();
    // Credits leave one per cycle straight out of reset
    repeat (Depth) add_step("release", 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    add_step("no_credit", 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    // Fill through the RAM while the pop side holds back, then drain in order
    repeat (Depth) add_step("fill", 1'b1, next_random_data(), 1'b0, 1'b0, 1'b0, '0, 1'b0);
    add_step("full", 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    repeat (Depth) add_step("drain", 1'b0, '0, 1'b1, 1'b0, 1'b0, '0, 1'b0);
    // Pushes into an empty FIFO go straight across
    repeat (2) add_step("bypass", 1'b1, next_random_data(), 1'b1, 1'b0, 1'b0, '0, 1'b0);
    add_step("after_bypass", 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    // Returned credits against a withhold of one, then stall and floor
    repeat (2) add_step("load", 1'b1, next_random_data(), 1'b0, 1'b0, 1'b0, '0, 1'b0);
    add_step("withhold_1", 1'b0, '0, 1'b0, 1'b0, 1'b1, credit_t'(1), 1'b0);
    repeat (2) add_step("pop_withheld", 1'b0, '0, 1'b1, 1'b0, 1'b0, '0, 1'b0);
    add_step("withhold_0", 1'b0, '0, 1'b0, 1'b1, 1'b1, '0, 1'b0);
    add_step("stalled", 1'b0, '0, 1'b0, 1'b1, 1'b0, '0, 1'b0);
    add_step("withhold_all", 1'b0, '0, 1'b0, 1'b1, 1'b1, '1, 1'b0);
    add_step("floor", 1'b0, '0, 1'b0, 1'b0, 1'b1, '0, 1'b0);
    add_step("release_held", 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
    // Overflow sets the sticky flag, which wins over a clear in the same cycle
    repeat (Depth) add_step("fill", 1'b1, next_random_data(), 1'b0, 1'b0, 1'b0, '0, 1'b0);
    add_step("overflow", 1'b1, next_random_data(), 1'b0, 1'b0, 1'b0, '0, 1'b0);
    add_step("overflow_clr", 1'b1, next_random_data(), 1'b0, 1'b0, 1'b0, '0, 1'b1);
    add_step("clear", 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b1);
    repeat (Depth) add_step("drain", 1'b0, '0, 1'b1, 1'b0, 1'b0, '0, 1'b0);
    add_step("idle", 1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // One table row: drive, check, advance the model
  // ----------------------------------------------------------------------

  task automatic run_step(input int i);
    int         err_before;
    int         plus;
    int         avail;
    logic       exp_credit;
    logic       exp_valid;
    logic       is_empty;
    logic       is_full;
    logic       accept;
    logic       pop;
    fifo_data_t exp_data;
    err_before        = errors;
    push_valid        = pv_q[i];
    push_data         = data_q[i];
    pop_ready         = pr_q[i];
    push_credit_stall = stall_q[i];
    cfg_wr            = wr_q[i];
    cfg_wdata         = wdata_q[i];
    cfg_clr           = clr_q[i];
    // A push while full is dropped, a push into an empty FIFO may bypass
    is_empty  = (model_q.size() == 0);
    is_full   = (model_q.size() == Depth);
    accept    = pv_q[i] && !is_full;
    exp_valid = !is_empty || ((`FIFO_BYPASS != 0) && accept);
    exp_data  = is_empty ? data_q[i] : model_q[0];
    pop       = exp_valid && pr_q[i];
    // A pop returns its credit at once, withhold caps the release
    plus       = model_credit + (pop ? 1 : 0);
    avail      = (plus > model_withhold) ? plus - model_withhold : 0;
    exp_credit = !stall_q[i] && (avail != 0);
    #(Period / 4);
    check_flag("push_credit", push_credit, exp_credit);
    check_credit("credit_available", credit_available, credit_t'(avail));
    check_credit("credit_count", credit_count, credit_t'(model_credit));
    check_flag("pop_valid", pop_valid, exp_valid);
    if (exp_valid) begin
      check_data("pop_data", pop_data, exp_data);
    end
    check_count("items", items, fifo_count_t'(model_q.size()));
    check_count("slots", slots, fifo_count_t'(Depth - model_q.size()));
    check_flag("full", full, is_full);
    check_flag("empty", empty, is_empty);
    check_flag("overflow_sticky", overflow_sticky, model_sticky);
    // State after the coming rising edge
    if (pop && !is_empty) begin
      void'(model_q.pop_front());
    end
    if (accept && !(is_empty && pop)) begin
      model_q.push_back(data_q[i]);
    end
    model_credit  = plus - (exp_credit ? 1 : 0);
    sender_credit = sender_credit + (exp_credit ? 1 : 0) - (accept ? 1 : 0);
    if (wr_q[i]) begin
      model_withhold = int'(wdata_q[i]);
    end
    if (pv_q[i] && is_full) begin
      model_sticky = 1'b1;
    end else if (clr_q[i]) begin
      model_sticky = 1'b0;
    end
    if (sender_credit < 0) begin
      errors++;
      $display("step %0d pushed an item while the sender held no credit", i);
    end
    $display("step %0d %s: %s", i, step_q[i], (errors == err_before) ? "ok" : "errors found");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------

  initial begin
    arst_n            = 1'b0;
    push_credit_stall = 1'b0;
    push_valid        = 1'b0;
    push_data         = '0;
    pop_ready         = 1'b0;
    cfg_wr            = 1'b0;
    cfg_clr           = 1'b0;
    cfg_wdata         = '0;
    errors            = 0;
    checks            = 0;
    model_credit      = Depth;
    model_withhold    = 0;
    sender_credit     = 0;
    model_sticky      = 1'b0;
    build_table();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    for (int i = 0; i < step_q.size(); i++) begin
      run_step(i);
      @(negedge clk);
    end
    $display("steps %0d, checks %0d, errors %0d", step_q.size(), checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Allows one period per table row plus a margin for the reset phase
  initial begin
    #1;
    #((step_q.size() + 20) * Period);
    $display("watchdog expired before the table of %0d steps finished", step_q.size());
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
fifo_pkg.sv
credit_pkg.sv
fifo_credit_cfg.sv
fifo_push_ctrl.sv
fifo_pop_ctrl.sv
fifo_ram_1r1w.sv
fifo_ctrl_1r1w_push_credit.sv
fifo_credit_top.sv
fifo_credit_props.sv
tb_fifo_credit.sv

// ==== run.sh ====
#!/bin/sh
# Builds the credit FIFO testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_fifo_credit -f compile.f -o sim_fifo_credit

./obj_dir/sim_fifo_credit | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1
